/* hw/sys_pkg.sv */
// Shared widths and host command codes; command values must match the host firmware
`default_nettype none

package sys_pkg;

	// ====================
	// Host I/O channel
	// ====================

	// One word on the strobed 16-bit channel
	typedef logic [15:0] io_word_t;

	// Command code, low byte of the first word in a frame
	typedef logic [7:0] hps_cmd_t;

	// Configuration word, csync flag at CFG_CSYNC_BIT
	localparam hps_cmd_t CMD_CFG = 8'h01;

	// LED override, upper byte mask and lower byte state
	localparam hps_cmd_t CMD_LED = 8'h25;

	// Volume word, attenuation in the low 5 bits
	localparam hps_cmd_t CMD_VOL = 8'h26;

	// Composite sync enable inside the configuration word
	localparam int unsigned CFG_CSYNC_BIT = 3;

	// Decoder FSM
	typedef enum logic {
		DEC_IDLE,
		DEC_HAVE_CMD
	} dec_state_e;

	// ====================
	// Board and audio
	// ====================

	// Main-board LEDs
	typedef logic [7:0] led_vec_t;

	// Bit 4 mutes, bits 3..0 are the right-shift count
	typedef logic [4:0] vol_att_t;

	// One audio sample, signed or unsigned by i_audio_s
	typedef logic [15:0] audio_sample_t;

	// Cross-mix amount: none, 1/8, 1/4, 1/2
	typedef logic [1:0] mix_mode_t;

endpackage

`default_nettype wire

/* hw/hps_io_decoder.sv */
// Host must not raise i_io_clk again before o_io_ack echoes it; i_io_din must be stable with the strobe
`timescale 1ns/1ps
`default_nettype none

module hps_io_decoder (
	input  wire                      clk_sys,
	input  wire                      resetd,
	input  wire                      i_io_uio,
	input  wire                      i_io_clk,
	input  wire sys_pkg::io_word_t   i_io_din,
	output logic                     o_io_ack,
	output sys_pkg::led_vec_t        o_led_override,
	output sys_pkg::led_vec_t        o_led_state,
	output sys_pkg::vol_att_t        o_vol_att,
	output logic                     o_csync
);

	// ====================
	// Strobe synchroniser
	// ====================

	logic [1:0] clk_sync;
	logic [1:0] uio_sync;
	logic       io_ack_q;
	logic       io_strobe;

	sys_pkg::dec_state_e state;
	sys_pkg::hps_cmd_t   cmd;

	// Ack is the synchronised strobe one cycle later, so it doubles as the edge reference
	assign io_strobe = clk_sync[1] & ~io_ack_q;
	assign o_io_ack  = io_ack_q;

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			clk_sync <= '0;
			uio_sync <= '0;
			io_ack_q <= 1'b0;
		end else begin
			clk_sync <= {clk_sync[0], i_io_clk};
			uio_sync <= {uio_sync[0], i_io_uio};
			io_ack_q <= clk_sync[1];
		end
	end

	// ====================
	// Command decode
	// ====================

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			state          <= sys_pkg::DEC_IDLE;
			o_led_override <= '0;
			o_led_state    <= '0;
			o_vol_att      <= '0;
			o_csync        <= 1'b0;
		end else if (!uio_sync[1]) begin
			// Frame closed, next word starts a new command
			state <= sys_pkg::DEC_IDLE;
		end else if (io_strobe) begin
			case (state)
				sys_pkg::DEC_IDLE: begin
					state <= sys_pkg::DEC_HAVE_CMD;
				end
				sys_pkg::DEC_HAVE_CMD: begin
					case (cmd)
						sys_pkg::CMD_CFG: begin
							o_csync <= i_io_din[sys_pkg::CFG_CSYNC_BIT];
						end
						sys_pkg::CMD_LED: begin
							o_led_override <= i_io_din[15:8];
							o_led_state    <= i_io_din[7:0];
						end
						sys_pkg::CMD_VOL: begin
							o_vol_att <= i_io_din[4:0];
						end
						default: begin
							// Unknown command, data words dropped
						end
					endcase
				end
				default: begin
					state <= sys_pkg::DEC_IDLE;
				end
			endcase
		end
	end

	// Command byte only matters while in DEC_HAVE_CMD
	always_ff @(posedge clk_sys) begin
		if (uio_sync[1] && io_strobe && state == sys_pkg::DEC_IDLE) begin
			cmd <= i_io_din[7:0];
		end
	end

endmodule

`default_nettype wire

/* hw/audio_mixer.sv */
// Two-cycle pipeline, no overflow saturation; sums wrap at 16 bits
`timescale 1ns/1ps
`default_nettype none

module audio_mixer (
	input  wire                         clk_sys,
	input  wire                         resetd,
	input  wire sys_pkg::audio_sample_t i_audio_l,
	input  wire sys_pkg::audio_sample_t i_audio_r,
	input  wire                         i_audio_s,
	input  wire sys_pkg::mix_mode_t     i_audio_mix,
	input  wire sys_pkg::vol_att_t      i_vol_att,
	output sys_pkg::audio_sample_t      o_audio_l,
	output sys_pkg::audio_sample_t      o_audio_r
);

	// Arithmetic shift for signed samples, logical otherwise
	function automatic sys_pkg::audio_sample_t shr(
		input sys_pkg::audio_sample_t v,
		input logic [3:0]             n,
		input logic                   s
	);
		logic signed [15:0] sv;
		sv = v;
		if (s) begin
			shr = sv >>> n;
		end else begin
			shr = v >> n;
		end
	endfunction

	// Own channel blended with a fraction of the other one
	function automatic sys_pkg::audio_sample_t mix(
		input sys_pkg::audio_sample_t own,
		input sys_pkg::audio_sample_t other,
		input sys_pkg::mix_mode_t     mode,
		input logic                   s
	);
		case (mode)
			2'd1:    mix = own - shr(own, 4'd3, s) + shr(other, 4'd3, s);
			2'd2:    mix = own - shr(own, 4'd2, s) + shr(other, 4'd2, s);
			2'd3:    mix = shr(own, 4'd1, s) + shr(other, 4'd1, s);
			default: mix = own;
		endcase
	endfunction

	sys_pkg::audio_sample_t mix_l;
	sys_pkg::audio_sample_t mix_r;
	logic                   mix_s;

	// Stage 1, cross-mix
	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			mix_l <= '0;
			mix_r <= '0;
			mix_s <= 1'b0;
		end else begin
			mix_l <= mix(i_audio_l, i_audio_r, i_audio_mix, i_audio_s);
			mix_r <= mix(i_audio_r, i_audio_l, i_audio_mix, i_audio_s);
			mix_s <= i_audio_s;
		end
	end

	// Stage 2, attenuation and mute
	always_ff @(posedge clk_sys) begin
		if (resetd || i_vol_att[4]) begin
			o_audio_l <= '0;
			o_audio_r <= '0;
		end else begin
			o_audio_l <= shr(mix_l, i_vol_att[3:0], mix_s);
			o_audio_r <= shr(mix_r, i_vol_att[3:0], mix_s);
		end
	end

endmodule

`default_nettype wire

/* hw/panel_io.sv */
// Buttons are active low and asynchronous; debounce time is 8 samples of DEB_DIV+1 cycles
`timescale 1ns/1ps
`default_nettype none

module panel_io #(
	parameter int DEB_DIV = 100000
) (
	input  wire                     clk_sys,
	input  wire                     resetd,
	input  wire                     i_btn_user_n,
	input  wire                     i_btn_osd_n,
	input  wire                     i_led_user,
	input  wire [1:0]               i_led_power,
	input  wire [1:0]               i_led_disk,
	input  wire sys_pkg::led_vec_t  i_led_override,
	input  wire sys_pkg::led_vec_t  i_led_state,
	output logic                    o_btn_user,
	output logic                    o_btn_osd,
	output sys_pkg::led_vec_t       o_led,
	output logic                    o_led_power_on,
	output logic                    o_led_hdd_on,
	output logic                    o_led_user_on
);

	localparam int DIV_W = $clog2(DEB_DIV + 1);

	// ====================
	// Button debounce
	// ====================

	logic [DIV_W-1:0] div_cnt;
	logic             deb_tick;
	logic [1:0]       btn_pressed;
	logic [1:0]       btn_out;

	assign deb_tick    = (div_cnt == '0);
	assign btn_pressed = {~i_btn_osd_n, ~i_btn_user_n};
	assign o_btn_user  = btn_out[0];
	assign o_btn_osd   = btn_out[1];

	always_ff @(posedge clk_sys) begin
		if (resetd || div_cnt == DIV_W'(DEB_DIV)) begin
			div_cnt <= '0;
		end else begin
			div_cnt <= div_cnt + 1'b1;
		end
	end

	for (genvar i = 0; i < 2; i++) begin : g_btn
		logic [1:0] sync;
		logic [7:0] hist;
		logic [7:0] hist_next;

		assign hist_next = {hist[6:0], sync[1]};

		always_ff @(posedge clk_sys) begin
			if (resetd) begin
				sync       <= '0;
				hist       <= '0;
				btn_out[i] <= 1'b0;
			end else begin
				sync <= {sync[0], btn_pressed[i]};
				if (deb_tick) begin
					hist <= hist_next;
					// Only a full run of equal samples moves the output
					if (&hist_next) begin
						btn_out[i] <= 1'b1;
					end else if (hist_next == '0) begin
						btn_out[i] <= 1'b0;
					end
				end
			end
		end
	end

	// ====================
	// LED drive
	// ====================

	logic led_p;
	logic led_d;
	logic led_u;

	assign led_p = i_led_power[1] ? i_led_power[0] : 1'b0;
	// Disk LED shows bit 0 in either mode
	assign led_d = i_led_disk[0];
	assign led_u = i_led_user;

	assign o_led_power_on = led_p;
	assign o_led_hdd_on   = led_d;
	assign o_led_user_on  = led_u;

	assign o_led = (i_led_override & i_led_state) |
		(~i_led_override & {3'b000, led_p, 1'b0, led_d, 1'b0, led_u});

endmodule

`default_nettype wire

/* hw/sync_polarity_fix.sv */
// Needs two full sync periods to settle; phases longer than 2**SYNC_CNT_W cycles wrap the count
`timescale 1ns/1ps
`default_nettype none

module sync_polarity_fix #(
	parameter int SYNC_CNT_W = 20
) (
	input  wire  clk_sys,
	input  wire  resetd,
	input  wire  i_sync,
	output logic o_sync
);

	logic                  s1;
	logic                  s2;
	logic                  pol;
	logic [SYNC_CNT_W-1:0] cnt;
	logic [SYNC_CNT_W-1:0] high_len;
	logic [SYNC_CNT_W-1:0] low_len;

	// Invert whenever the high phase is the long one
	assign o_sync = s1 ^ pol;

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			s1       <= 1'b0;
			s2       <= 1'b0;
			pol      <= 1'b0;
			cnt      <= '0;
			high_len <= '0;
			low_len  <= '0;
		end else begin
			s1 <= i_sync;
			s2 <= s1;
			// Rising edge closes a low phase, falling edge a high one
			if (s1 && !s2) begin
				low_len <= cnt;
			end
			if (!s1 && s2) begin
				high_len <= cnt;
			end
			if (s1 != s2) begin
				cnt <= '0;
			end else begin
				cnt <= cnt + 1'b1;
			end
			pol <= (high_len > low_len);
		end
	end

endmodule

`default_nettype wire

/* hw/vga_sync_out.sv */
// Syncs of either polarity in, active-low VGA syncs out; composite sync is XOR based
`timescale 1ns/1ps
`default_nettype none

module vga_sync_out #(
	parameter int SYNC_CNT_W = 20
) (
	input  wire  clk_sys,
	input  wire  resetd,
	input  wire  i_vs,
	input  wire  i_hs,
	input  wire  i_csync,
	output logic o_vga_vs,
	output logic o_vga_hs
);

	logic vs_norm;
	logic hs_norm;

	sync_polarity_fix #(
		.SYNC_CNT_W(SYNC_CNT_W)
	) sync_v_i (
		.clk_sys(clk_sys),
		.resetd (resetd),
		.i_sync (i_vs),
		.o_sync (vs_norm)
	);

	sync_polarity_fix #(
		.SYNC_CNT_W(SYNC_CNT_W)
	) sync_h_i (
		.clk_sys(clk_sys),
		.resetd (resetd),
		.i_sync (i_hs),
		.o_sync (hs_norm)
	);

	// In composite mode VS idles high and HS carries both
	assign o_vga_vs = i_csync ? 1'b1 : ~vs_norm;
	assign o_vga_hs = i_csync ? ~(vs_norm ^ hs_norm) : ~hs_norm;

endmodule

`default_nettype wire

/* hw/sys_top.sv */
// Single clock domain; every input is expected on clk_sys except the buttons and host strobe
`timescale 1ns/1ps
`default_nettype none

module sys_top #(
	parameter int DEB_DIV    = 100000,
	parameter int SYNC_CNT_W = 20
) (
	input  wire                         clk_sys,
	input  wire                         resetd,
	input  wire                         i_io_uio,
	input  wire                         i_io_clk,
	input  wire sys_pkg::io_word_t      i_io_din,
	input  wire                         i_btn_user_n,
	input  wire                         i_btn_osd_n,
	input  wire                         i_led_user,
	input  wire [1:0]                   i_led_power,
	input  wire [1:0]                   i_led_disk,
	input  wire sys_pkg::audio_sample_t i_audio_l,
	input  wire sys_pkg::audio_sample_t i_audio_r,
	input  wire                         i_audio_s,
	input  wire sys_pkg::mix_mode_t     i_audio_mix,
	input  wire                         i_vs,
	input  wire                         i_hs,
	output logic                        o_io_ack,
	output logic                        o_btn_user,
	output logic                        o_btn_osd,
	output sys_pkg::led_vec_t           o_led,
	output logic                        o_led_power_on,
	output logic                        o_led_hdd_on,
	output logic                        o_led_user_on,
	output sys_pkg::audio_sample_t      o_audio_l,
	output sys_pkg::audio_sample_t      o_audio_r,
	output logic                        o_vga_hs,
	output logic                        o_vga_vs
);

	// Configuration from the host
	sys_pkg::led_vec_t led_override;
	sys_pkg::led_vec_t led_state;
	sys_pkg::vol_att_t vol_att;
	logic              csync;

	hps_io_decoder hps_io_decoder_i (
		.clk_sys       (clk_sys),
		.resetd        (resetd),
		.i_io_uio      (i_io_uio),
		.i_io_clk      (i_io_clk),
		.i_io_din      (i_io_din),
		.o_io_ack      (o_io_ack),
		.o_led_override(led_override),
		.o_led_state   (led_state),
		.o_vol_att     (vol_att),
		.o_csync       (csync)
	);

	panel_io #(
		.DEB_DIV(DEB_DIV)
	) panel_io_i (
		.clk_sys       (clk_sys),
		.resetd        (resetd),
		.i_btn_user_n  (i_btn_user_n),
		.i_btn_osd_n   (i_btn_osd_n),
		.i_led_user    (i_led_user),
		.i_led_power   (i_led_power),
		.i_led_disk    (i_led_disk),
		.i_led_override(led_override),
		.i_led_state   (led_state),
		.o_btn_user    (o_btn_user),
		.o_btn_osd     (o_btn_osd),
		.o_led         (o_led),
		.o_led_power_on(o_led_power_on),
		.o_led_hdd_on  (o_led_hdd_on),
		.o_led_user_on (o_led_user_on)
	);

	audio_mixer audio_mixer_i (
		.clk_sys    (clk_sys),
		.resetd     (resetd),
		.i_audio_l  (i_audio_l),
		.i_audio_r  (i_audio_r),
		.i_audio_s  (i_audio_s),
		.i_audio_mix(i_audio_mix),
		.i_vol_att  (vol_att),
		.o_audio_l  (o_audio_l),
		.o_audio_r  (o_audio_r)
	);

	vga_sync_out #(
		.SYNC_CNT_W(SYNC_CNT_W)
	) vga_sync_out_i (
		.clk_sys (clk_sys),
		.resetd  (resetd),
		.i_vs    (i_vs),
		.i_hs    (i_hs),
		.i_csync (csync),
		.o_vga_vs(o_vga_vs),
		.o_vga_hs(o_vga_hs)
	);

endmodule

`default_nettype wire

/* tb/sys_top_properties.sv */
// Checks mute, host ack echo and reset values at the sys_top boundary; bound to every sys_top
`timescale 1ns/1ps
`default_nettype none

module sys_top_properties (
	input wire                         clk_sys,
	input wire                         resetd,
	input wire                         i_io_clk,
	input wire                         i_io_ack,
	input wire sys_pkg::vol_att_t      i_vol_att,
	input wire sys_pkg::audio_sample_t i_audio_l,
	input wire sys_pkg::audio_sample_t i_audio_r
);

	// Mute reaches the stage 2 register directly
	mute_zero: assert property (@(posedge clk_sys) disable iff (resetd)
		i_vol_att[4] |=> (i_audio_l == '0 && i_audio_r == '0))
		else $error("mute did not force zero audio outputs");

	// Two synchroniser stages plus the ack register
	ack_echo: assert property (@(posedge clk_sys) disable iff (resetd)
		(!$past(resetd, 1) && !$past(resetd, 2) && !$past(resetd, 3))
		|-> (i_io_ack == $past(i_io_clk, 3)))
		else $error("io ack does not echo the synchronised strobe");

	reset_zero: assert property (@(posedge clk_sys)
		resetd |=> (!i_io_ack && i_audio_l == '0 && i_audio_r == '0))
		else $error("outputs not cleared by reset");

endmodule

bind sys_top sys_top_properties sys_top_properties_i (
	.clk_sys  (clk_sys),
	.resetd   (resetd),
	.i_io_clk (i_io_clk),
	.i_io_ack (o_io_ack),
	.i_vol_att(vol_att),
	.i_audio_l(o_audio_l),
	.i_audio_r(o_audio_r)
);

`default_nettype wire

/* tb/sys_top_tb.sv */
// Directed test of sys_top built with DEB_DIV 4; the sync train is fixed, samples come from an LFSR
`timescale 1ns/1ps
`default_nettype none

module sys_top_tb;

	localparam int DEB_DIV     = 4;
	localparam int HALF_PERIOD = 50;

	// ====================
	// Run length
	// ====================

	localparam int WORD_CYC    = 13;
	localparam int FRAME_CYC   = 4 + 2 * WORD_CYC + 3;
	localparam int STEP_CYC    = 3;
	localparam int SAMPLES     = 6;
	localparam int HS_PERIOD   = 20;
	localparam int HS_LOW      = 3;
	localparam int VS_PERIOD   = 200;
	localparam int VS_LOW      = 20;
	localparam int SYNC_SETTLE = 2 * VS_PERIOD + 20;
	localparam int SYNC_CHECK  = 400;
	localparam int BTN_LIMIT   = 8 * (DEB_DIV + 1) + 4;

	localparam int T_RESET = 4 + 4;
	localparam int T_LED   = 2 * FRAME_CYC + 2 * WORD_CYC + 4;
	localparam int T_AUDIO = 2 * 4 * SAMPLES * STEP_CYC;
	localparam int T_VOL   = 3 * FRAME_CYC + 20 * STEP_CYC + 2;
	localparam int T_SYNC  = SYNC_SETTLE + 2 * SYNC_CHECK + 20 + 2 * FRAME_CYC + 4;
	localparam int T_BTN   = 4 * BTN_LIMIT + 20;
	localparam int CYCLE_LIMIT = T_RESET + T_LED + T_AUDIO + T_VOL + T_SYNC + T_BTN + 200;

	logic                   clk_sys = 1'b0;
	logic                   resetd;
	logic                   i_io_uio;
	logic                   i_io_clk;
	sys_pkg::io_word_t      i_io_din;
	logic                   i_btn_user_n;
	logic                   i_btn_osd_n;
	logic                   i_led_user;
	logic [1:0]             i_led_power;
	logic [1:0]             i_led_disk;
	sys_pkg::audio_sample_t i_audio_l;
	sys_pkg::audio_sample_t i_audio_r;
	logic                   i_audio_s;
	sys_pkg::mix_mode_t     i_audio_mix;
	logic                   i_vs;
	logic                   i_hs;
	logic                   o_io_ack;
	logic                   o_btn_user;
	logic                   o_btn_osd;
	sys_pkg::led_vec_t      o_led;
	logic                   o_led_power_on;
	logic                   o_led_hdd_on;
	logic                   o_led_user_on;
	sys_pkg::audio_sample_t o_audio_l;
	sys_pkg::audio_sample_t o_audio_r;
	logic                   o_vga_hs;
	logic                   o_vga_vs;

	// Host-side copy of the configuration
	sys_pkg::led_vec_t exp_mask;
	sys_pkg::led_vec_t exp_state;
	sys_pkg::vol_att_t cur_att;

	logic [31:0] lfsr_state;
	logic        sync_run = 1'b0;
	int          sync_pos = 0;
	int          cycle_cnt;
	int          err_count;
	int          test_err_base;
	int          tests_run;
	int          tests_failed;
	string       cur_test;

	sys_top #(
		.DEB_DIV   (DEB_DIV),
		.SYNC_CNT_W(16)
	) dut_i (
		.clk_sys       (clk_sys),
		.resetd        (resetd),
		.i_io_uio      (i_io_uio),
		.i_io_clk      (i_io_clk),
		.i_io_din      (i_io_din),
		.i_btn_user_n  (i_btn_user_n),
		.i_btn_osd_n   (i_btn_osd_n),
		.i_led_user    (i_led_user),
		.i_led_power   (i_led_power),
		.i_led_disk    (i_led_disk),
		.i_audio_l     (i_audio_l),
		.i_audio_r     (i_audio_r),
		.i_audio_s     (i_audio_s),
		.i_audio_mix   (i_audio_mix),
		.i_vs          (i_vs),
		.i_hs          (i_hs),
		.o_io_ack      (o_io_ack),
		.o_btn_user    (o_btn_user),
		.o_btn_osd     (o_btn_osd),
		.o_led         (o_led),
		.o_led_power_on(o_led_power_on),
		.o_led_hdd_on  (o_led_hdd_on),
		.o_led_user_on (o_led_user_on),
		.o_audio_l     (o_audio_l),
		.o_audio_r     (o_audio_r),
		.o_vga_hs      (o_vga_hs),
		.o_vga_vs      (o_vga_vs)
	);

	always #HALF_PERIOD clk_sys = ~clk_sys;

	// Active-low sync train, one line every HS_PERIOD cycles
	always @(negedge clk_sys) begin
		if (sync_run) begin
			sync_pos <= (sync_pos == VS_PERIOD - 1) ? 0 : sync_pos + 1;
			i_hs     <= (sync_pos % HS_PERIOD) >= HS_LOW;
			i_vs     <= sync_pos >= VS_LOW;
		end
	end

	// ====================
	// Reference model
	// ====================

	// Galois LFSR, x^32 + x^22 + x^2 + x + 1, one step per bit
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		logic        lsb;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lsb        = lfsr_state[0];
			lfsr_state = lfsr_state >> 1;
			if (lsb) begin
				lfsr_state = lfsr_state ^ 32'h8020_0003;
			end
			v[i] = lsb;
		end
		return v;
	endfunction

	// Sign bits fill from the left for signed samples
	function automatic sys_pkg::audio_sample_t ref_shift(
		input sys_pkg::audio_sample_t v,
		input logic [3:0]             n,
		input logic                   s
	);
		logic [31:0] ext;
		ext = {(s && v[15]) ? 16'hffff : 16'h0000, v};
		ext = ext >> n;
		return ext[15:0];
	endfunction

	function automatic sys_pkg::audio_sample_t ref_mix(
		input sys_pkg::audio_sample_t own,
		input sys_pkg::audio_sample_t other,
		input sys_pkg::mix_mode_t     mode,
		input logic                   s
	);
		sys_pkg::audio_sample_t res;
		if (mode == 2'd0) begin
			res = own;
		end else if (mode == 2'd3) begin
			res = ref_shift(own, 4'd1, s) + ref_shift(other, 4'd1, s);
		end else begin
			res = own - ref_shift(own, 4'd4 - mode, s) + ref_shift(other, 4'd4 - mode, s);
		end
		return res;
	endfunction

	function automatic sys_pkg::led_vec_t led_expect();
		sys_pkg::led_vec_t def;
		def    = '0;
		def[0] = i_led_user;
		def[2] = i_led_disk[0];
		def[4] = i_led_power[1] & i_led_power[0];
		return (exp_mask & exp_state) | (~exp_mask & def);
	endfunction

	// ====================
	// Compare tasks
	// ====================

	task automatic check_led(input string what, input sys_pkg::led_vec_t exp,
		input sys_pkg::led_vec_t act);
		if (act !== exp) begin
			$display("CHECK FAILED [%s] %s: expected %h, actual %h", cur_test, what, exp, act);
			err_count++;
		end
	endtask

	task automatic check_sample(input string what, input sys_pkg::audio_sample_t exp,
		input sys_pkg::audio_sample_t act);
		if (act !== exp) begin
			$display("CHECK FAILED [%s] %s: expected %h, actual %h", cur_test, what, exp, act);
			err_count++;
		end
	endtask

	task automatic check_bit(input string what, input logic exp, input logic act);
		if (act !== exp) begin
			$display("CHECK FAILED [%s] %s: expected %b, actual %b", cur_test, what, exp, act);
			err_count++;
		end
	endtask

	task automatic start_test(input string name);
		cur_test      = name;
		test_err_base = err_count;
	endtask

	task automatic end_test();
		tests_run++;
		if (err_count == test_err_base) begin
			$display("test %-8s passed", cur_test);
		end else begin
			tests_failed++;
			$display("test %-8s FAILED with %0d errors", cur_test, err_count - test_err_base);
		end
	endtask

	// ====================
	// Host channel
	// ====================

	task automatic send_word(input sys_pkg::io_word_t w);
		@(negedge clk_sys);
		i_io_din = w;
		i_io_clk = 1'b1;
		repeat (6) @(negedge clk_sys);
		check_bit("io_ack high", 1'b1, o_io_ack);
		i_io_clk = 1'b0;
		repeat (6) @(negedge clk_sys);
		check_bit("io_ack low", 1'b0, o_io_ack);
	endtask

	task automatic send_frame(input sys_pkg::hps_cmd_t cmd, input sys_pkg::io_word_t data);
		@(negedge clk_sys);
		i_io_uio = 1'b1;
		repeat (3) @(negedge clk_sys);
		send_word({8'h00, cmd});
		send_word(data);
		i_io_uio = 1'b0;
		repeat (3) @(negedge clk_sys);
	endtask

	// One sample pair through both pipeline stages
	task automatic audio_step(input logic s, input sys_pkg::mix_mode_t m);
		sys_pkg::audio_sample_t l;
		sys_pkg::audio_sample_t r;
		sys_pkg::audio_sample_t exp_l;
		sys_pkg::audio_sample_t exp_r;
		l     = 16'(rand_bits(16));
		r     = 16'(rand_bits(16));
		exp_l = cur_att[4] ? '0 : ref_shift(ref_mix(l, r, m, s), cur_att[3:0], s);
		exp_r = cur_att[4] ? '0 : ref_shift(ref_mix(r, l, m, s), cur_att[3:0], s);
		@(negedge clk_sys);
		i_audio_l   = l;
		i_audio_r   = r;
		i_audio_s   = s;
		i_audio_mix = m;
		repeat (2) @(negedge clk_sys);
		check_sample("audio_l", exp_l, o_audio_l);
		check_sample("audio_r", exp_r, o_audio_r);
	endtask

	// Sampled before the train moves on, so i_hs and i_vs hold last cycle's values
	task automatic check_sync(input int cycles, input logic comp);
		repeat (cycles) begin
			@(negedge clk_sys);
			check_bit("vga_vs", comp ? 1'b1 : i_vs, o_vga_vs);
			check_bit("vga_hs", comp ? ~(i_vs ^ i_hs) : i_hs, o_vga_hs);
		end
	endtask

	// ====================
	// Tests
	// ====================

	task automatic test_reset();
		start_test("reset");
		@(negedge clk_sys);
		check_bit("io_ack", 1'b0, o_io_ack);
		check_bit("btn_user", 1'b0, o_btn_user);
		check_bit("btn_osd", 1'b0, o_btn_osd);
		check_sample("audio_l", '0, o_audio_l);
		check_sample("audio_r", '0, o_audio_r);
		i_led_user  = 1'(rand_bits(1));
		i_led_power = 2'(rand_bits(2));
		i_led_disk  = 2'(rand_bits(2));
		@(negedge clk_sys);
		check_led("led default", led_expect(), o_led);
		check_bit("power_on", i_led_power[1] & i_led_power[0], o_led_power_on);
		check_bit("hdd_on", i_led_disk[0], o_led_hdd_on);
		check_bit("user_on", i_led_user, o_led_user_on);
		end_test();
	endtask

	task automatic test_led();
		sys_pkg::led_vec_t mask;
		sys_pkg::led_vec_t state;
		start_test("led");
		mask  = 8'(rand_bits(8));
		state = 8'(rand_bits(8));
		send_frame(sys_pkg::CMD_LED, {mask, state});
		exp_mask  = mask;
		exp_state = state;
		check_led("led override", led_expect(), o_led);
		// Words outside a frame and unknown commands leave it alone
		send_word(16'(rand_bits(16)));
		send_word(16'(rand_bits(16)));
		check_led("led stray words", led_expect(), o_led);
		send_frame(8'h7f, 16'(rand_bits(16)));
		check_led("led unknown cmd", led_expect(), o_led);
		i_led_user  = 1'(rand_bits(1));
		i_led_power = 2'(rand_bits(2));
		i_led_disk  = 2'(rand_bits(2));
		@(negedge clk_sys);
		check_led("led new inputs", led_expect(), o_led);
		end_test();
	endtask

	task automatic test_audio();
		start_test("audio");
		for (int s = 0; s < 2; s++) begin
			for (int m = 0; m < 4; m++) begin
				repeat (SAMPLES) audio_step(s[0], 2'(m));
			end
		end
		end_test();
	endtask

	task automatic test_volume();
		sys_pkg::vol_att_t att;
		start_test("volume");
		att = {1'b0, 4'd1 + 4'(rand_bits(4) % 15)};
		send_frame(sys_pkg::CMD_VOL, {11'd0, att});
		cur_att = att;
		for (int s = 0; s < 2; s++) begin
			for (int m = 0; m < 4; m++) begin
				repeat (2) audio_step(s[0], 2'(m));
			end
		end
		att = 5'h10 | 5'(rand_bits(4));
		send_frame(sys_pkg::CMD_VOL, {11'd0, att});
		cur_att = att;
		repeat (4) audio_step(1'(rand_bits(1)), 2'(rand_bits(2)));
		send_frame(sys_pkg::CMD_VOL, 16'h0000);
		cur_att = '0;
		end_test();
	endtask

	task automatic test_sync();
		sys_pkg::io_word_t cfg;
		start_test("sync");
		@(posedge clk_sys);
		sync_run = 1'b1;
		repeat (SYNC_SETTLE) @(negedge clk_sys);
		check_sync(SYNC_CHECK, 1'b0);
		cfg = 16'(rand_bits(16));
		cfg[sys_pkg::CFG_CSYNC_BIT] = 1'b1;
		send_frame(sys_pkg::CMD_CFG, cfg);
		check_sync(SYNC_CHECK, 1'b1);
		send_frame(sys_pkg::CMD_CFG, 16'h0000);
		check_sync(20, 1'b0);
		end_test();
	endtask

	task automatic test_buttons();
		int waited;
		start_test("buttons");
		@(negedge clk_sys);
		i_btn_user_n = 1'b0;
		waited = 0;
		while (!o_btn_user && waited < BTN_LIMIT) begin
			@(negedge clk_sys);
			waited++;
		end
		if (!o_btn_user) begin
			$display("[%s] held press did not set the user button within %0d cycles",
				cur_test, BTN_LIMIT);
			err_count++;
		end
		check_bit("btn_osd", 1'b0, o_btn_osd);
		i_btn_user_n = 1'b1;
		waited = 0;
		while (o_btn_user && waited < BTN_LIMIT) begin
			@(negedge clk_sys);
			waited++;
		end
		if (o_btn_user) begin
			$display("[%s] release did not clear the user button within %0d cycles",
				cur_test, BTN_LIMIT);
			err_count++;
		end
		// One-cycle glitches 7 cycles apart, so one of them meets a debounce sample
		for (int g = 0; g < DEB_DIV + 1; g++) begin
			@(negedge clk_sys);
			i_btn_user_n = 1'b0;
			@(negedge clk_sys);
			i_btn_user_n = 1'b1;
			repeat (DEB_DIV + 1) begin
				@(negedge clk_sys);
				check_bit("btn_user glitch", 1'b0, o_btn_user);
			end
		end
		end_test();
	endtask

	// ====================
	// Main flow
	// ====================

	initial begin
		resetd       = 1'b1;
		i_io_uio     = 1'b0;
		i_io_clk     = 1'b0;
		i_io_din     = '0;
		i_btn_user_n = 1'b1;
		i_btn_osd_n  = 1'b1;
		i_led_user   = 1'b0;
		i_led_power  = 2'b00;
		i_led_disk   = 2'b00;
		i_audio_l    = '0;
		i_audio_r    = '0;
		i_audio_s    = 1'b0;
		i_audio_mix  = 2'd0;
		i_vs         = 1'b1;
		i_hs         = 1'b1;
		exp_mask     = '0;
		exp_state    = '0;
		cur_att      = '0;
		lfsr_state   = 32'h09ad_2a28;
		err_count    = 0;
		tests_run    = 0;
		tests_failed = 0;
		repeat (4) @(posedge clk_sys);
		@(negedge clk_sys);
		resetd = 1'b0;

		test_reset();
		test_led();
		test_audio();
		test_volume();
		test_sync();
		test_buttons();

		$display("summary: %0d tests, %0d failed, %0d check errors",
			tests_run, tests_failed, err_count);
		if (err_count == 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

	initial begin
		cycle_cnt = 0;
		while (cycle_cnt < CYCLE_LIMIT) begin
			@(posedge clk_sys);
			cycle_cnt++;
		end
		$display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
		$display("STATUS: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

/* sys_top.f */
hw/sys_pkg.sv
hw/hps_io_decoder.sv
hw/audio_mixer.sv
hw/panel_io.sv
hw/sync_polarity_fix.sv
hw/vga_sync_out.sv
hw/sys_top.sv
tb/sys_top_properties.sv
tb/sys_top_tb.sv

/* Bender.yml */
package:
  name: sys_top

sources:
  - hw/sys_pkg.sv
  - hw/hps_io_decoder.sv
  - hw/audio_mixer.sv
  - hw/panel_io.sv
  - hw/sync_polarity_fix.sv
  - hw/vga_sync_out.sv
  - hw/sys_top.sv
  - target: test
    files:
      - tb/sys_top_properties.sv
      - tb/sys_top_tb.sv
